//--- tb.f
logic/cam_pkg.sv
logic/sccb_master.sv
logic/sensor_init_sequencer.sv
logic/pixel_capture.sv
logic/camera_capture_top.sv
tests/sensor_model.sv
tests/tb_camera.sv

//--- tests/tb_camera.sv
module tb_camera;
    timeunit 1ns;
    timeprecision 100ps;

    import cam_pkg::*;

    logic              ov7670_pclk;
    logic              reset;
    logic              ov7670_vsync;
    logic              ov7670_href;
    logic [7:0]        ov7670_data;
    logic              ov7670_sioc;
    wire               ov7670_siod;
    logic              ov7670_reset;
    logic              ov7670_pwdn;
    logic [addr_w-1:0] mem_addr;
    logic [15:0]       mem_data;
    logic              mem_wren;
    logic              config_done;

    logic [addr_w-1:0] wr_addr_q[$];
    logic [15:0]       wr_data_q[$];
    logic [addr_w-1:0] exp_addr_q[$];
    logic [15:0]       exp_data_q[$];
    logic [15:0]       mem_image [img_width * img_height];
    int                errors;
    int                tests_run;
    int                seed;

    pullup (ov7670_siod);   // Open-drain data line

    camera_capture_top dut0 (
        .ov7670_pclk  (ov7670_pclk),
        .reset        (reset),
        .ov7670_vsync (ov7670_vsync),
        .ov7670_href  (ov7670_href),
        .ov7670_data  (ov7670_data),
        .ov7670_sioc  (ov7670_sioc),
        .ov7670_siod  (ov7670_siod),
        .ov7670_reset (ov7670_reset),
        .ov7670_pwdn  (ov7670_pwdn),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .mem_wren     (mem_wren),
        .config_done  (config_done)
    );

    sensor_model sensor0 (
        .ov7670_pclk  (ov7670_pclk),
        .ov7670_sioc  (ov7670_sioc),
        .ov7670_siod  (ov7670_siod),
        .ov7670_vsync (ov7670_vsync),
        .ov7670_href  (ov7670_href),
        .ov7670_data  (ov7670_data)
    );

    always #10 ov7670_pclk = ~ov7670_pclk;

    // Write port monitor samples away from the active edge
    always @(negedge ov7670_pclk) begin
        if (mem_wren === 1'b1) begin
            wr_addr_q.push_back(mem_addr);
            wr_data_q.push_back(mem_data);
        end
    end

    task automatic compare(input string test, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("mismatch in %s, %s: expected %0h, actual %0h",
                     test, what, expected, actual);
        end
    endtask

    task automatic finish_test(input string test, input int err0);
        tests_run++;
        $display("%s finished with %0d errors", test, errors - err0);
    endtask

    // RGB565 to RGB444 keeps the top bits of each channel
    function automatic logic [15:0] expected_pixel(input logic [7:0] hb, input logic [7:0] lb);
        logic [4:0] r5;
        logic [5:0] g6;
        r5 = hb[7:3];
        g6 = {hb[2:0], lb[7:5]};
        return {4'h0, r5[4:1], g6[5:2], lb[4:1]};
    endfunction

    task automatic clear_queues();
        wr_addr_q.delete();
        wr_data_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
    endtask

    // Random bytes go to the model and expected writes to the queues
    task automatic build_frame(input int lines, input int bytes_per_line);
        int          line;
        int          n;
        int unsigned rnd;
        logic [7:0]  hb;
        logic [7:0]  b;
        hb = 8'h00;
        for (line = 0; line < lines; line++) begin
            for (n = 0; n < bytes_per_line; n++) begin
                rnd = $urandom;
                b   = rnd[7:0];
                sensor0.load_byte(b);
                if (n % 2 == 0) begin
                    hb = b;
                end else if (n / 2 < img_width && line < img_height) begin
                    exp_addr_q.push_back(addr_w'(line * img_width + n / 2));
                    exp_data_q.push_back(expected_pixel(hb, b));
                end
            end
        end
    endtask

    task automatic wait_writes(input string test, input int count, input int limit);
        int cycles;
        cycles = 0;
        while (wr_addr_q.size() < count && cycles < limit) begin
            @(posedge ov7670_pclk);
            cycles++;
        end
        if (wr_addr_q.size() < count) begin
            errors++;
            $display("timeout waiting for %0d memory writes in %s, only %0d seen",
                     count, test, wr_addr_q.size());
        end
        repeat (8) @(posedge ov7670_pclk);   // Catch any extra writes
    endtask

    task automatic wait_config(input int limit);
        int cycles;
        cycles = 0;
        while (config_done !== 1'b1 && cycles < limit) begin
            @(posedge ov7670_pclk);
            cycles++;
        end
        if (config_done !== 1'b1) begin
            errors++;
            $display("timeout waiting for config_done after %0d cycles", limit);
        end
    endtask

    task automatic compare_writes(input string test);
        int i;
        int n;
        int err0;
        err0 = errors;
        compare(test, "write count", exp_addr_q.size(), wr_addr_q.size());
        n = (exp_addr_q.size() < wr_addr_q.size()) ? exp_addr_q.size() : wr_addr_q.size();
        for (i = 0; i < n && errors - err0 < 10; i++) begin
            compare(test, $sformatf("address of write %0d", i), exp_addr_q[i], wr_addr_q[i]);
            compare(test, $sformatf("data of write %0d", i), exp_data_q[i], wr_data_q[i]);
        end
    endtask

    task automatic run_frame(input string test, input int lines, input int bytes_per_line);
        clear_queues();
        build_frame(lines, bytes_per_line);
        sensor0.send_frame(lines, bytes_per_line);
        wait_writes(test, exp_addr_q.size(), 200);
        compare_writes(test);
    endtask

    task automatic check_reset_state();
        int err0;
        err0 = errors;
        @(posedge ov7670_pclk);
        #2;
        compare("reset_state", "ov7670_reset during reset", 0, ov7670_reset);
        compare("reset_state", "ov7670_pwdn during reset", 0, ov7670_pwdn);
        repeat (2) @(posedge ov7670_pclk);
        #2;
        reset = 1'b0;
        #1;
        compare("reset_state", "mem_wren", 0, mem_wren);
        compare("reset_state", "config_done", 0, config_done);
        compare("reset_state", "sioc", 1, ov7670_sioc);
        compare("reset_state", "siod", 1, ov7670_siod);
        compare("reset_state", "ov7670_reset after reset", 1, ov7670_reset);
        compare("reset_state", "ov7670_pwdn", 0, ov7670_pwdn);
        finish_test("reset_state", err0);
    endtask

    // Sensor streams before it has been configured
    task automatic ignore_early_frame();
        int err0;
        err0 = errors;
        clear_queues();
        build_frame(4, 16);
        sensor0.send_frame(4, 16);
        repeat (10) @(posedge ov7670_pclk);
        compare("early_frame", "config_done after frame", 0, config_done);
        compare("early_frame", "write count", 0, wr_addr_q.size());
        finish_test("early_frame", err0);
    endtask

    task automatic verify_configuration();
        int          err0;
        int          i;
        logic [23:0] entry;
        logic [15:0] table_entry;
        err0 = errors;
        wait_config(20000);
        compare("configuration", "SCCB write count", init_count, sensor0.log_count);
        compare("configuration", "malformed SCCB writes", 0, sensor0.bad_writes);
        for (i = 0; i < init_count && i < sensor0.log_count; i++) begin
            entry       = sensor0.sccb_log[i];
            table_entry = init_reg_table[i];
            compare("configuration", $sformatf("write %0d device id", i), 8'h42, entry[23:16]);
            compare("configuration", $sformatf("write %0d register", i),
                    table_entry[15:8], entry[15:8]);
            compare("configuration", $sformatf("write %0d value", i),
                    table_entry[7:0], entry[7:0]);
        end
        finish_test("configuration", err0);
    endtask

    task automatic capture_full_frame();
        int err0;
        err0 = errors;
        run_frame("full_frame", img_height, 2 * img_width);
        finish_test("full_frame", err0);
    endtask

    task automatic clip_wide_lines();
        int err0;
        err0 = errors;
        run_frame("wide_lines", 3, 2 * 210);   // Columns 200 to 209 dropped
        finish_test("wide_lines", err0);
    endtask

    task automatic clip_tall_frame();
        int err0;
        err0 = errors;
        run_frame("tall_frame", 165, 8);
        finish_test("tall_frame", err0);
    endtask

    task automatic drop_half_pixel();
        int err0;
        err0 = errors;
        run_frame("odd_bytes", 3, 11);   // Five pixels and a lone byte per line
        finish_test("odd_bytes", err0);
    endtask

    task automatic capture_two_frames();
        int err0;
        int err1;
        int i;
        int frame_px;
        err0     = errors;
        frame_px = img_width * img_height;
        clear_queues();
        build_frame(img_height, 2 * img_width);
        sensor0.send_frame(img_height, 2 * img_width);
        build_frame(img_height, 2 * img_width);
        sensor0.send_frame(img_height, 2 * img_width);
        wait_writes("two_frames", exp_addr_q.size(), 200);
        compare_writes("two_frames");
        if (wr_addr_q.size() > frame_px)
            compare("two_frames", "second frame first address", 0, wr_addr_q[frame_px]);
        for (i = 0; i < wr_addr_q.size(); i++) begin
            if (wr_addr_q[i] < frame_px) mem_image[wr_addr_q[i]] = wr_data_q[i];
        end
        err1 = errors;
        for (i = 0; i < frame_px && errors - err1 < 10; i++) begin
            compare("two_frames", $sformatf("memory word %0d", i),
                    exp_data_q[frame_px + i], mem_image[i]);
        end
        finish_test("two_frames", err0);
    endtask

    initial begin
        ov7670_pclk = 1'b0;
        reset       = 1'b1;
        errors      = 0;
        tests_run   = 0;
        seed        = 32'hbc57;
        void'($urandom(seed));
        check_reset_state();
        ignore_early_frame();
        verify_configuration();
        capture_full_frame();
        clip_wide_lines();
        clip_tall_frame();
        drop_half_pixel();
        capture_two_frames();
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- tests/sensor_model.sv
module sensor_model (
    input  logic       ov7670_pclk,
    input  logic       ov7670_sioc,
    input  wire        ov7670_siod,
    output logic       ov7670_vsync,
    output logic       ov7670_href,
    output logic [7:0] ov7670_data
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  byte_q[$];          // Pixel bytes waiting to be sent
    logic [23:0] sccb_log [16];      // Device id, register, value
    int          log_count;
    int          bad_writes;
    logic        in_write;
    logic        prev_c;
    logic        prev_d;
    logic        cur_d;
    logic [27:0] bits;
    int          nbits;

    initial begin
        ov7670_vsync = 1'b0;
        ov7670_href  = 1'b0;
        ov7670_data  = 8'h00;
        log_count    = 0;
        bad_writes   = 0;
        in_write     = 1'b0;
        prev_c       = 1'b1;
        prev_d       = 1'b1;
        bits         = '0;
        nbits        = 0;
    end

    // Bus is sampled mid cycle, where sioc and siod have settled
    always @(negedge ov7670_pclk) begin
        cur_d = (ov7670_siod === 1'b0) ? 1'b0 : 1'b1;
        if (prev_c && ov7670_sioc === 1'b1 && prev_d && !cur_d) begin
            in_write = 1'b1;   // Start condition
            nbits    = 0;
        end else if (in_write && prev_c && ov7670_sioc === 1'b1 && !prev_d && cur_d) begin
            in_write = 1'b0;   // Stop condition
            // The clock pulse of the stop was shifted in as a 28th bit
            if (nbits == 28 && log_count < 16) begin
                sccb_log[log_count] = {bits[27:20], bits[18:11], bits[9:2]};
                log_count++;
            end else begin
                bad_writes++;
            end
        end else if (in_write && !prev_c && ov7670_sioc === 1'b1) begin
            bits = {bits[26:0], cur_d};   // Rising sioc
            nbits++;
        end
        prev_c = (ov7670_sioc === 1'b1);
        prev_d = cur_d;
    end

    task automatic step();
        @(posedge ov7670_pclk);
        #2;
    endtask

    task automatic load_byte(input logic [7:0] b);
        byte_q.push_back(b);
    endtask

    // Vsync pulse, then lines with a short blanking gap after each
    task automatic send_frame(input int lines, input int bytes_per_line);
        int line;
        int n;
        step();
        ov7670_vsync = 1'b1;
        repeat (3) step();
        step();
        ov7670_vsync = 1'b0;
        repeat (4) step();
        for (line = 0; line < lines; line++) begin
            for (n = 0; n < bytes_per_line; n++) begin
                step();
                ov7670_href = 1'b1;
                ov7670_data = (byte_q.size() > 0) ? byte_q.pop_front() : 8'h00;
            end
            step();
            ov7670_href = 1'b0;
            ov7670_data = 8'h00;
            repeat (5) step();
        end
    endtask

endmodule

//--- logic/camera_capture_top.sv
module camera_capture_top (
    input  logic                       ov7670_pclk,
    input  logic                       reset,
    input  logic                       ov7670_vsync,
    input  logic                       ov7670_href,
    input  logic [7:0]                 ov7670_data,
    output logic                       ov7670_sioc,
    inout  wire                        ov7670_siod,
    output logic                       ov7670_reset,
    output logic                       ov7670_pwdn,
    output logic [cam_pkg::addr_w-1:0] mem_addr,
    output logic [15:0]                mem_data,
    output logic                       mem_wren,
    output logic                       config_done
);

    logic       sccb_req;
    logic       sccb_ack;
    logic [7:0] sccb_reg;
    logic [7:0] sccb_val;

    assign ov7670_reset = ~reset;   // Sensor reset is active low
    assign ov7670_pwdn  = 1'b0;     // Always powered

    sensor_init_sequencer init0 (
        .ov7670_pclk (ov7670_pclk),
        .reset       (reset),
        .sccb_ack    (sccb_ack),
        .sccb_req    (sccb_req),
        .sccb_reg    (sccb_reg),
        .sccb_val    (sccb_val),
        .config_done (config_done)
    );

    sccb_master sccb0 (
        .ov7670_pclk (ov7670_pclk),
        .reset       (reset),
        .sccb_req    (sccb_req),
        .sccb_reg    (sccb_reg),
        .sccb_val    (sccb_val),
        .sccb_ack    (sccb_ack),
        .sioc        (ov7670_sioc),
        .siod        (ov7670_siod)
    );

    // Pixel path, free running once configured
    pixel_capture cap0 (
        .ov7670_pclk  (ov7670_pclk),
        .reset        (reset),
        .config_done  (config_done),
        .ov7670_vsync (ov7670_vsync),
        .ov7670_href  (ov7670_href),
        .ov7670_data  (ov7670_data),
        .mem_addr     (mem_addr),
        .mem_data     (mem_data),
        .mem_wren     (mem_wren)
    );

endmodule

//--- logic/pixel_capture.sv
module pixel_capture (
    input  logic                       ov7670_pclk,
    input  logic                       reset,
    input  logic                       config_done,
    input  logic                       ov7670_vsync,
    input  logic                       ov7670_href,
    input  logic [7:0]                 ov7670_data,
    output logic [cam_pkg::addr_w-1:0] mem_addr,
    output logic [15:0]                mem_data,
    output logic                       mem_wren
);
    import cam_pkg::*;

    capture_state_t    state;
    logic              vsync_d;
    logic              href_d;
    logic              vsync_fall;
    logic              vsync_rise;
    logic              href_rise;
    logic              href_fall;
    logic [7:0]        high_byte;
    logic [col_w-1:0]  col;
    logic [line_w-1:0] line;
    logic              take_high;
    logic              take_low;
    logic              pix_write;
    logic              last_line;
    logic [3:0]        red4;
    logic [3:0]        green4;
    logic [3:0]        blue4;

    always_ff @(posedge ov7670_pclk or posedge reset) begin
        if (reset) begin
            vsync_d <= 1'b0;
            href_d  <= 1'b0;
        end else begin
            vsync_d <= ov7670_vsync;
            href_d  <= ov7670_href;
        end
    end

    assign vsync_fall = vsync_d & ~ov7670_vsync;
    assign vsync_rise = ~vsync_d & ov7670_vsync;
    assign href_rise  = ov7670_href & ~href_d;
    assign href_fall  = ~ov7670_href & href_d;

    // First byte of every line is a high byte
    assign take_high = (state == cap_wait_line && href_rise) ||
                       (state == cap_capture_high && ov7670_href);
    assign take_low  = (state == cap_capture_low) && ov7670_href;
    assign pix_write = take_low && (col < col_w'(img_width)) &&
                       (line < line_w'(img_height));
    assign last_line = (line == line_w'(img_height - 1));

    // RGB565 high byte RRRRRGGG, low byte GGGBBBBB
    assign red4   = high_byte[7:4];
    assign green4 = {high_byte[2:0], ov7670_data[7]};
    assign blue4  = ov7670_data[4:1];

    always_ff @(posedge ov7670_pclk or posedge reset) begin
        if (reset) begin
            state <= cap_idle;
            col   <= '0;
            line  <= '0;
        end else if (vsync_fall && config_done) begin
            state <= cap_wait_line;   // New frame
            col   <= '0;
            line  <= '0;
        end else if (vsync_rise) begin
            state <= cap_idle;
        end else if ((state == cap_capture_high || state == cap_capture_low) && href_fall) begin
            // End of line, any half pixel is dropped
            line <= line + 1'b1;
            if (last_line) state <= cap_idle;
            else state <= cap_wait_line;
        end else begin
            case (state)
                cap_idle: ;
                cap_wait_line: begin
                    if (href_rise) begin
                        col   <= '0;
                        state <= cap_capture_low;
                    end
                end
                cap_capture_high: begin
                    if (ov7670_href) state <= cap_capture_low;
                end
                cap_capture_low: begin
                    if (ov7670_href) begin
                        state <= cap_capture_high;
                        if (col < col_w'(img_width)) col <= col + 1'b1;   // Saturates
                    end
                end
                default: state <= cap_idle;
            endcase
        end
    end

    always_ff @(posedge ov7670_pclk or posedge reset) begin
        if (reset) mem_wren <= 1'b0;
        else mem_wren <= pix_write;   // One cycle per pixel
    end

    always_ff @(posedge ov7670_pclk) begin
        if (take_high) high_byte <= ov7670_data;
        if (pix_write) begin
            mem_addr <= addr_w'(line * img_width + col);
            mem_data <= {4'h0, red4, green4, blue4};
        end
    end

endmodule

//--- logic/sensor_init_sequencer.sv
module sensor_init_sequencer (
    input  logic       ov7670_pclk,
    input  logic       reset,
    input  logic       sccb_ack,
    output logic       sccb_req,
    output logic [7:0] sccb_reg,
    output logic [7:0] sccb_val,
    output logic       config_done
);
    import cam_pkg::*;

    init_state_t           state;
    logic [init_idx_w-1:0] index;
    logic                  last_entry;

    assign last_entry = (index == init_idx_w'(init_count - 1));

    always_ff @(posedge ov7670_pclk or posedge reset) begin
        if (reset) begin
            state <= init_send;
            index <= '0;
        end else begin
            case (state)
                init_send: begin
                    if (sccb_ack) state <= init_release;   // Write went out
                end
                init_release: begin
                    // Wait for ack to drop before the next request
                    if (!sccb_ack) begin
                        if (last_entry) begin
                            state <= init_done;
                        end else begin
                            index <= index + 1'b1;
                            state <= init_send;
                        end
                    end
                end
                init_done: ;
                default: state <= init_send;
            endcase
        end
    end

    assign sccb_req               = (state == init_send);
    assign {sccb_reg, sccb_val}   = init_reg_table[index];   // Stable while req is high
    assign config_done            = (state == init_done);

endmodule

//--- logic/sccb_master.sv
module sccb_master (
    input  logic       ov7670_pclk,
    input  logic       reset,
    input  logic       sccb_req,
    input  logic [7:0] sccb_reg,
    input  logic [7:0] sccb_val,
    output logic       sccb_ack,
    output logic       sioc,
    inout  wire        siod
);
    import cam_pkg::*;

    sccb_state_t           state;
    logic [sccb_div_w-1:0] div_cnt;
    logic [1:0]            quarter;
    logic [sccb_bit_w-1:0] bit_cnt;
    logic [sccb_bits-1:0]  shift_reg;
    logic                  quarter_tick;
    logic                  bit_end;
    logic                  siod_low;

    assign quarter_tick = (div_cnt == sccb_div_w'(sccb_div - 1));
    assign bit_end      = quarter_tick && (quarter == 2'd3);

    always_ff @(posedge ov7670_pclk or posedge reset) begin
        if (reset) begin
            state   <= sccb_idle;
            bit_cnt <= '0;
        end else begin
            case (state)
                sccb_idle: begin
                    if (sccb_req) state <= sccb_start;
                end
                sccb_start: begin
                    if (bit_end) begin
                        state   <= sccb_shift;
                        bit_cnt <= '0;
                    end
                end
                sccb_shift: begin
                    if (bit_end) begin
                        if (bit_cnt == sccb_bit_w'(sccb_bits - 1)) state <= sccb_stop;
                        else bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                sccb_stop: begin
                    if (bit_end) state <= sccb_done;
                end
                sccb_done: begin
                    if (!sccb_req) state <= sccb_idle;   // Four-phase release
                end
                default: state <= sccb_idle;
            endcase
        end
    end

    // Quarter-bit timebase, only runs while the bus is busy
    always_ff @(posedge ov7670_pclk or posedge reset) begin
        if (reset) begin
            div_cnt <= '0;
            quarter <= '0;
        end else if (state == sccb_idle || state == sccb_done) begin
            div_cnt <= '0;
            quarter <= '0;
        end else if (quarter_tick) begin
            div_cnt <= '0;
            quarter <= quarter + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // A one in the shifter releases the line, so ninth bits float
    always_ff @(posedge ov7670_pclk) begin
        if (state == sccb_idle && sccb_req)
            shift_reg <= {sensor_write_id, 1'b1, sccb_reg, 1'b1, sccb_val, 1'b1};
        else if (state == sccb_shift && bit_end)
            shift_reg <= {shift_reg[sccb_bits-2:0], 1'b1};
    end

    always_comb begin
        sioc     = 1'b1;
        siod_low = 1'b0;
        case (state)
            sccb_start: begin
                sioc     = (quarter != 2'd3);
                siod_low = quarter[1];   // Data falls while clock is high
            end
            sccb_shift: begin
                sioc     = (quarter == 2'd1) || (quarter == 2'd2);
                siod_low = ~shift_reg[sccb_bits-1];
            end
            sccb_stop: begin
                sioc     = (quarter != 2'd0);
                siod_low = (quarter != 2'd3);   // Data rises while clock is high
            end
            default: ;
        endcase
    end

    assign siod     = siod_low ? 1'b0 : 1'bz;   // Open drain
    assign sccb_ack = (state == sccb_done);

endmodule

//--- logic/cam_pkg.sv
package cam_pkg;

    // Frame buffer geometry
    localparam int img_width  = 200;
    localparam int img_height = 160;
    localparam int addr_w     = 15;
    localparam int col_w      = $clog2(img_width + 1);
    localparam int line_w     = $clog2(img_height + 1);

    // SCCB bit timing, in pclk cycles per quarter bit
    localparam int sccb_div   = 4;
    localparam int sccb_div_w = $clog2(sccb_div);
    localparam int sccb_bits  = 27;   // Three bytes, each with a ninth bit
    localparam int sccb_bit_w = $clog2(sccb_bits);

    localparam logic [7:0] sensor_write_id = 8'h42;

    // Register address in the upper byte, value in the lower byte
    localparam int init_count = 6;
    localparam int init_idx_w = $clog2(init_count);
    localparam logic [15:0] init_reg_table [init_count] = '{
        16'h1280,   // COM7 soft reset
        16'h1204,   // COM7 RGB output
        16'h40d0,   // COM15 RGB565, full range
        16'h0c04,   // COM3 scale enable
        16'h3e1a,   // COM14 pclk divider and manual scaling
        16'h703a    // Horizontal scale
    };

    typedef enum logic [1:0] {
        cap_idle,
        cap_wait_line,
        cap_capture_high,
        cap_capture_low
    } capture_state_t;

    typedef enum logic [2:0] {
        sccb_idle,
        sccb_start,
        sccb_shift,
        sccb_stop,
        sccb_done
    } sccb_state_t;

    typedef enum logic [1:0] {
        init_send,
        init_release,
        init_done
    } init_state_t;

endpackage
